// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = tb_dual_writeback
FILELIST  = dual_writeback.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep '\.sv$$' $(FILELIST)) tb/wb_model.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf $(OBJ_DIR)

// File: dual_writeback.f
+incdir+tb
source/core_pkg.sv
source/slot_pipereg.sv
source/regfile.sv
source/operand_bypass.sv
source/hilo_unit.sv
source/dual_writeback.sv
tb/tb_dual_writeback.sv

// File: source/core_pkg.sv
package core_pkg;

    // datapath widths
    localparam int word_w = 32;
    localparam int reg_addr_w = 5;

    // issue width and register file read ports, two sources per lane
    localparam int num_lanes = 2;
    localparam int num_read_ports = 2 * num_lanes;

    typedef logic [word_w-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // multiplier product or hi:lo accumulator
    typedef logic [2*word_w-1:0] dword_t;

    // how a lane updates hi/lo
    typedef enum logic [1:0] {
        hilo_set = 2'd0,
        hilo_add = 2'd1,
        hilo_sub = 2'd2
    } hilo_op_t;

    // one instruction lane entering writeback
    typedef struct packed {
        logic      valid;
        // general register write
        logic      regwrite;
        reg_addr_t rdst;
        word_t     wd;
        // hi/lo write
        logic      hiwrite;
        logic      lowrite;
        hilo_op_t  hilo_op;
        // mthi/mtlo, value comes from srca
        logic      is_move;
        word_t     srca;
        dword_t    product;
    } wb_lane_t;

    // registered read addresses for all read ports
    typedef reg_addr_t [num_read_ports-1:0] read_req_t;

endpackage

// File: source/dual_writeback.sv
`timescale 1ns/10ps

module dual_writeback (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic [core_pkg::num_lanes-1:0]                     i_lane_valid,
    input  logic [core_pkg::num_lanes-1:0]                     i_regwrite,
    input  core_pkg::reg_addr_t [core_pkg::num_lanes-1:0]      i_rdst,
    input  core_pkg::word_t [core_pkg::num_lanes-1:0]          i_wd,
    input  logic [core_pkg::num_lanes-1:0]                     i_hiwrite,
    input  logic [core_pkg::num_lanes-1:0]                     i_lowrite,
    input  core_pkg::hilo_op_t [core_pkg::num_lanes-1:0]       i_hilo_op,
    input  logic [core_pkg::num_lanes-1:0]                     i_is_move,
    input  core_pkg::word_t [core_pkg::num_lanes-1:0]          i_srca,
    input  core_pkg::dword_t [core_pkg::num_lanes-1:0]         i_product,
    input  logic                                               i_flush,
    input  core_pkg::reg_addr_t [core_pkg::num_read_ports-1:0] i_ra,
    output core_pkg::word_t [core_pkg::num_read_ports-1:0]     o_rd,
    output core_pkg::word_t                                    o_hi,
    output core_pkg::word_t                                    o_lo
);
    import core_pkg::*;

    wb_lane_t [num_lanes-1:0] lane_in;
    wb_lane_t [num_lanes-1:0] lane_w;

    read_req_t [1:0] ra_in;
    read_req_t [1:0] ra_q;

    logic [num_lanes-1:0] rf_we;
    reg_addr_t [num_lanes-1:0] rf_wa;
    word_t [num_lanes-1:0] rf_wd;
    word_t [num_read_ports-1:0] rf_rd;

    // pack loose lane ports into the stage payload
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            lane_in[l].valid    = i_lane_valid[l];
            lane_in[l].regwrite = i_regwrite[l];
            lane_in[l].rdst     = i_rdst[l];
            lane_in[l].wd       = i_wd[l];
            lane_in[l].hiwrite  = i_hiwrite[l];
            lane_in[l].lowrite  = i_lowrite[l];
            lane_in[l].hilo_op  = i_hilo_op[l];
            lane_in[l].is_move  = i_is_move[l];
            lane_in[l].srca     = i_srca[l];
            lane_in[l].product  = i_product[l];
        end
    end

    // M3 -> W stage register
    slot_pipereg #(.T(wb_lane_t)) u_wb_stage (
        .clk,
        .reset,
        .i_en    (1'b1),
        .i_flush (i_flush),
        .i_in    (lane_in),
        .o_out   (lane_w)
    );

    // read addresses ride in slot 0, slot 1 is idle
    assign ra_in = {read_req_t'(0), i_ra};

    slot_pipereg #(.T(read_req_t)) u_read_stage (
        .clk,
        .reset,
        .i_en    (1'b1),
        .i_flush (1'b0),
        .i_in    (ra_in),
        .o_out   (ra_q)
    );

    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            rf_we[l] = lane_w[l].valid && lane_w[l].regwrite;
            rf_wa[l] = lane_w[l].rdst;
            rf_wd[l] = lane_w[l].wd;
        end
    end

    regfile u_regfile (
        .clk,
        .reset,
        .i_we (rf_we),
        .i_wa (rf_wa),
        .i_wd (rf_wd),
        .i_ra (ra_q[0]),
        .o_rd (rf_rd)
    );

    // lanes still in W are not in the register file yet
    operand_bypass u_operand_bypass (
        .i_lane  (lane_w),
        .i_ra    (ra_q[0]),
        .i_rf_rd (rf_rd),
        .o_rd    (o_rd)
    );

    hilo_unit u_hilo_unit (
        .clk,
        .reset,
        .i_lane (lane_w),
        .o_hi   (o_hi),
        .o_lo   (o_lo)
    );

endmodule

// File: source/hilo_unit.sv
`timescale 1ns/10ps

module hilo_unit (
    input  logic                                         clk,
    input  logic                                         reset,
    input  core_pkg::wb_lane_t [core_pkg::num_lanes-1:0] i_lane,
    output core_pkg::word_t                              o_hi,
    output core_pkg::word_t                              o_lo
);
    import core_pkg::*;

    word_t hi_q;
    word_t lo_q;
    word_t hi_d;
    word_t lo_d;
    dword_t committed;
    dword_t [num_lanes-1:0] acc;

    assign committed = {hi_q, lo_q};

    // madd/msub work on hi:lo committed by earlier cycles
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            if (i_lane[l].hilo_op == hilo_sub) begin
                acc[l] = committed - i_lane[l].product;
            end else begin
                acc[l] = committed + i_lane[l].product;
            end
        end
    end

    // older lane first, the last writer of each half wins
    always_comb begin
        dword_t src;
        hi_d = hi_q;
        lo_d = lo_q;
        for (int l = num_lanes - 1; l >= 0; l--) begin
            if (i_lane[l].is_move) begin
                // mthi/mtlo, same word offered to both halves
                src = {i_lane[l].srca, i_lane[l].srca};
            end else if (i_lane[l].hilo_op == hilo_set) begin
                src = i_lane[l].product;
            end else begin
                src = acc[l];
            end
            if (i_lane[l].valid && i_lane[l].hiwrite) begin
                hi_d = src[2*word_w-1:word_w];
            end
            if (i_lane[l].valid && i_lane[l].lowrite) begin
                lo_d = src[word_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            hi_q <= hi_d;
            lo_q <= lo_d;
        end
    end

    assign o_hi = hi_q;
    assign o_lo = lo_q;

    for (genvar l = 0; l < num_lanes; l++) begin : g_lane_chk
        // accumulate always rewrites the full 64-bit pair
        a_acc_both: assert property (@(posedge clk) disable iff (reset)
            (i_lane[l].valid && i_lane[l].hilo_op != hilo_set
                && (i_lane[l].hiwrite || i_lane[l].lowrite))
            |-> (i_lane[l].hiwrite && i_lane[l].lowrite));
        // decode never marks a move as accumulating
        a_move_set: assert property (@(posedge clk) disable iff (reset)
            (i_lane[l].valid && i_lane[l].is_move) |-> (i_lane[l].hilo_op == hilo_set));
    end

endmodule

// File: source/operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass (
    input  core_pkg::wb_lane_t [core_pkg::num_lanes-1:0]      i_lane,
    input  core_pkg::reg_addr_t [core_pkg::num_read_ports-1:0] i_ra,
    input  core_pkg::word_t [core_pkg::num_read_ports-1:0]    i_rf_rd,
    output core_pkg::word_t [core_pkg::num_read_ports-1:0]    o_rd
);
    import core_pkg::*;

    // lane carries a pending write to this address
    function automatic logic fwd_hit(input wb_lane_t lane, input reg_addr_t ra);
        logic hit;
        hit = lane.valid && lane.regwrite;
        // r0 is never forwarded
        hit = hit && (lane.rdst != '0);
        return hit && (lane.rdst == ra);
    endfunction

    logic [num_read_ports-1:0][num_lanes-1:0] hit;

    always_comb begin
        for (int p = 0; p < num_read_ports; p++) begin
            for (int l = 0; l < num_lanes; l++) begin
                hit[p][l] = fwd_hit(i_lane[l], i_ra[p]);
            end
        end
    end

    // register file value unless a W-stage lane matches
    always_comb begin
        for (int p = 0; p < num_read_ports; p++) begin
            o_rd[p] = i_rf_rd[p];
            // walk older to younger, so lane 0 has the last word
            for (int l = num_lanes - 1; l >= 0; l--) begin
                if (hit[p][l]) begin
                    o_rd[p] = i_lane[l].wd;
                end
            end
        end
    end

endmodule

// File: source/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic [core_pkg::num_lanes-1:0]                    i_we,
    input  core_pkg::reg_addr_t [core_pkg::num_lanes-1:0]     i_wa,
    input  core_pkg::word_t [core_pkg::num_lanes-1:0]         i_wd,
    input  core_pkg::reg_addr_t [core_pkg::num_read_ports-1:0] i_ra,
    output core_pkg::word_t [core_pkg::num_read_ports-1:0]    o_rd
);
    import core_pkg::*;

    // register zero has no storage
    word_t regs [1:(2**reg_addr_w)-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 1; r < 2**reg_addr_w; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // older lane first, lane 0 lands last and wins
            for (int l = num_lanes - 1; l >= 0; l--) begin
                if (i_we[l] && i_wa[l] != '0) begin
                    regs[i_wa[l]] <= i_wd[l];
                end
            end
        end
    end

    // combinational read
    always_comb begin
        for (int p = 0; p < num_read_ports; p++) begin
            o_rd[p] = (i_ra[p] == '0) ? '0 : regs[i_ra[p]];
        end
    end

endmodule

// File: source/slot_pipereg.sv
`timescale 1ns/10ps

module slot_pipereg #(
    parameter type T = logic [31:0]
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   i_en,
    input  logic   i_flush,
    input  T [1:0] i_in,
    output T [1:0] o_out
);

    // both slots share enable and flush
    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            // all-zero payload means no valid lane
            o_out <= '0;
        end else if (i_en) begin
            o_out <= i_in;
        end
    end

endmodule

// File: tb/wb_model.svh
`ifndef WB_MODEL_SVH
`define WB_MODEL_SVH

// architectural registers and hi/lo after every applied lane
word_t m_regs [0:31];
word_t m_hi;
word_t m_lo;

function automatic void reset_model();
    for (int r = 0; r < 32; r++) begin
        m_regs[r] = '0;
    end
    m_hi = '0;
    m_lo = '0;
endfunction

// one surviving lane; committed is hi:lo from earlier cycles only
function automatic void apply_lane(
    input logic     valid,
    input logic     regwrite,
    input reg_addr_t rdst,
    input word_t    wd,
    input logic     hiwrite,
    input logic     lowrite,
    input hilo_op_t op,
    input logic     is_move,
    input word_t    srca,
    input dword_t   product,
    input dword_t   committed
);
    dword_t val;
    if (!valid) begin
        return;
    end
    // r0 stays zero
    if (regwrite && rdst != 5'd0) begin
        m_regs[rdst] = wd;
    end
    if (is_move) begin
        if (hiwrite) m_hi = srca;
        if (lowrite) m_lo = srca;
    end else begin
        case (op)
            hilo_add: val = committed + product;
            hilo_sub: val = committed - product;
            default:  val = product;
        endcase
        if (hiwrite) m_hi = val[63:32];
        if (lowrite) m_lo = val[31:0];
    end
endfunction

`endif

// File: tb/tb_dual_writeback.sv
`timescale 1ns/10ps

module tb_dual_writeback;
    import core_pkg::*;

    localparam int reset_cycles = 16;
    localparam int n_test_cycles = 2000;
    // test length plus half again as margin
    localparam int cycle_limit = n_test_cycles + n_test_cycles / 2;
    localparam int unsigned seed = 32'hc4cfdcb1;

    logic clk = 1'b0;
    logic reset;
    logic flush;
    logic [1:0] lane_valid;
    logic [1:0] regwrite;
    reg_addr_t [1:0] rdst;
    word_t [1:0] wd;
    logic [1:0] hiwrite;
    logic [1:0] lowrite;
    hilo_op_t [1:0] hilo_op;
    logic [1:0] is_move;
    word_t [1:0] srca;
    dword_t [1:0] product;
    reg_addr_t [3:0] ra;
    word_t [3:0] rd;
    word_t hi;
    word_t lo;

    int n_errors = 0;
    int n_checks = 0;
    int cycles = 0;
    int unsigned seed_ret;
    // expected reads one cycle out, hi:lo two cycles out
    word_t [3:0] exp_rd;
    dword_t exp_hilo_q1;
    dword_t exp_hilo_q2;

    `include "wb_model.svh"

    dual_writeback u_dual_writeback (
        .clk          (clk),
        .reset        (reset),
        .i_lane_valid (lane_valid),
        .i_regwrite   (regwrite),
        .i_rdst       (rdst),
        .i_wd         (wd),
        .i_hiwrite    (hiwrite),
        .i_lowrite    (lowrite),
        .i_hilo_op    (hilo_op),
        .i_is_move    (is_move),
        .i_srca       (srca),
        .i_product    (product),
        .i_flush      (flush),
        .i_ra         (ra),
        .o_rd         (rd),
        .o_hi         (hi),
        .o_lo         (lo)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic verify_hilo(input dword_t got, input dword_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR {o_hi,o_lo}: got 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic check_outputs();
        for (int p = 0; p < 4; p++) begin
            compare_word($sformatf("o_rd[%0d]", p), rd[p], exp_rd[p]);
        end
        verify_hilo({hi, lo}, exp_hilo_q2);
    endtask

    // new lanes and read addresses, then advance the model
    task automatic drive_cycle(input int idx, input bit lanes_on);
        dword_t committed;
        int unsigned pick;
        logic coin;
        committed = {m_hi, m_lo};
        flush = lanes_on && ($urandom % 8 == 0);
        for (int l = 0; l < 2; l++) begin
            pick = $urandom % 5;
            coin = ($urandom % 2 == 0);
            lane_valid[l] = lanes_on && ($urandom % 4 != 0);
            regwrite[l] = ($urandom % 2 == 0);
            rdst[l] = reg_addr_t'($urandom % 8);
            wd[l] = $urandom;
            srca[l] = $urandom;
            product[l] = {$urandom, $urandom};
            // 0 none, 1 move, 2 set, 3 add, 4 sub
            is_move[l] = (pick == 1);
            hiwrite[l] = (pick == 1) ? coin : (pick != 0);
            lowrite[l] = (pick == 1) ? !coin : ((pick == 2) ? coin : (pick != 0));
            hilo_op[l] = (pick == 3) ? hilo_add : ((pick == 4) ? hilo_sub : hilo_set);
        end
        if ($urandom % 4 == 0) begin
            rdst[0] = rdst[1];
        end
        for (int p = 0; p < 4; p++) begin
            ra[p] = lanes_on ? reg_addr_t'($urandom % 8) : reg_addr_t'(4 * idx + p);
        end
        if (!flush) begin
            for (int l = 1; l >= 0; l--) begin
                apply_lane(lane_valid[l], regwrite[l], rdst[l], wd[l], hiwrite[l],
                    lowrite[l], hilo_op[l], is_move[l], srca[l], product[l], committed);
            end
        end
        for (int p = 0; p < 4; p++) begin
            exp_rd[p] = m_regs[ra[p]];
        end
        exp_hilo_q2 = exp_hilo_q1;
        exp_hilo_q1 = {m_hi, m_lo};
    endtask

    initial begin
        seed_ret = $urandom(seed);
        reset = 1'b1;
        flush = 1'b0;
        lane_valid = '0;
        regwrite = '0;
        rdst = '0;
        wd = '0;
        hiwrite = '0;
        lowrite = '0;
        hilo_op[0] = hilo_set;
        hilo_op[1] = hilo_set;
        is_move = '0;
        srca = '0;
        product = '0;
        ra = '0;
        exp_rd = '0;
        exp_hilo_q1 = '0;
        exp_hilo_q2 = '0;
        reset_model();
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        // idle cycles at both ends sweep all 32 registers
        for (int i = 0; i < n_test_cycles; i++) begin
            check_outputs();
            drive_cycle(i, i >= 8 && i < n_test_cycles - 8);
            @(posedge clk);
            #1;
        end
        check_outputs();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
